//--- verification/rv32_decode_input.txt
// instr opcode type alu_op imm rd rs1 rs2 fence_pred fence_succ zimm trap, all hex
// opcode, type and alu_op use the rv32_pkg enum encodings
123452b7 01 4 1 12345000 05 08 03 0 0 00 0
1234560b 3f 7 0 00000000 0c 08 03 0 0 00 1
fffff517 02 4 1 fffff000 0a 1f 1f 0 0 00 0
001000ef 03 5 1 00000800 01 00 01 0 0 00 0
ffdff06f 03 5 1 fffffffc 00 1f 1d 0 0 00 0
010100e7 04 1 1 00000010 01 02 10 0 0 00 0
00208463 05 3 b 00000008 08 01 02 0 0 00 0
0020a463 3f 7 0 00000000 08 01 02 0 0 00 1
fe4198e3 06 3 c fffffff0 11 03 04 0 0 00 0
0062c263 07 3 6 00000004 04 05 06 0 0 00 0
0083d663 08 3 d 0000000c 0c 07 08 0 0 00 0
00a4e0e3 09 3 7 00000800 01 09 0a 0 0 00 0
80c5f063 0a 3 e fffff000 00 0b 0c 0 0 00 0
fff10083 0b 1 1 ffffffff 01 02 1f 0 0 00 0
7fe35283 0f 1 1 000007fe 05 06 1e 0 0 00 0
fe742c23 12 2 1 fffffff8 18 08 07 0 0 00 0
80010093 13 1 1 fffff800 01 02 00 0 0 00 0
00000013 00 6 0 00000000 00 00 00 0 0 00 0
00123193 15 1 7 00000001 03 04 01 0 0 00 0
fff34293 16 1 8 ffffffff 05 06 1f 0 0 00 0
00309093 19 1 3 00000003 01 01 03 0 0 00 0
01f1d113 1a 1 4 0000001f 02 03 1f 0 0 00 0
4072d213 1b 1 5 00000407 04 05 07 0 0 00 0
003100b3 1c 0 1 00000000 01 02 03 0 0 00 0
023100b3 3f 7 0 00000000 01 02 03 0 0 00 1
40628233 1d 0 2 00000000 04 05 06 0 0 00 0
009453b3 22 0 4 00000000 07 08 09 0 0 00 0
40c5d533 23 0 5 00000000 0a 0b 0c 0 0 00 0
03a0000f 26 1 0 0000003a 00 00 1a 3 a 00 0
0000100f 27 1 0 00000000 00 00 00 0 0 00 0
0000108f 3f 7 0 00000000 01 00 00 0 0 00 1
00000073 28 1 0 00000000 00 00 00 0 0 00 0
00008073 3f 7 0 00000000 00 01 00 0 0 00 1
300110f3 2a 1 0 00000300 01 02 00 0 0 00 0
3413e2f3 2e 1 0 00000341 05 07 01 0 0 07 0
fffff373 2f 1 0 ffffffff 06 1f 1f 0 0 1f 0

//--- filelist.f
source/rv32_pkg.sv
source/rv32_imm_gen.sv
source/rv32_decoder.sv
source/rv32_instr_queue.sv
source/rv32_decode_reg.sv
source/rv32_decode_top.sv
verification/rv32_decode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the decode stage testbench with Verilator.
# Runs from the project root so the testbench finds its vector file.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f filelist.f --top-module rv32_decode_tb \
    -o rv32_decode_sim &&
    ./obj_dir/rv32_decode_sim 2>&1 | tee "$LOG" ||
    echo "Build or simulation returned an error"

grep -q "^TEST PASSED$" "$LOG" 2>/dev/null && echo "Simulation passed" ||
    { echo "Simulation failed, see $LOG"; exit 1; }

//--- verification/rv32_decode_tb.sv
// ----------------------------------------------------------------------
// Testbench for the RV32I decode stage. Run from the project root, the
// vector file is opened by relative path. Stops at the first error.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rv32_decode_tb;

    import rv32_pkg::*;

    localparam int QUEUE_DEPTH = RV32_QUEUE_DEPTH_DEFAULT;
    localparam int MAX_VECTORS = 64;
    localparam int NUM_COLUMNS = 12;

    logic              clk;
    logic              reset;
    rv32_instr_t       in_instr;
    logic              in_valid;
    logic              in_ready;
    logic              out_valid;
    logic              out_ready;
    rv32_opcode_enum_t out_opcode;
    rv32_type_enum_t   out_type;
    rv32_alu_op_t      out_alu_op;
    rv32_register_t    out_rs1;
    rv32_register_t    out_rs2;
    rv32_register_t    out_rd;
    rv32_imm_t         out_imm;
    rv32_fence_t       out_fence_pred;
    rv32_fence_t       out_fence_succ;
    rv32_zimm_t        out_zimm;
    logic              out_trap;

    // Columns: instr opcode type alu imm rd rs1 rs2 pred succ zimm trap
    logic [31:0] vec_field [MAX_VECTORS][NUM_COLUMNS];
    int          num_vectors = 0;
    int          in_count    = 0;
    int          out_count   = 0;
    int          cycle_count = 0;

    rv32_decode_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .clk            (clk),
        .reset          (reset),
        .in_instr       (in_instr),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_opcode     (out_opcode),
        .out_type       (out_type),
        .out_alu_op     (out_alu_op),
        .out_rs1        (out_rs1),
        .out_rs2        (out_rs2),
        .out_rd         (out_rd),
        .out_imm        (out_imm),
        .out_fence_pred (out_fence_pred),
        .out_fence_succ (out_fence_succ),
        .out_zimm       (out_zimm),
        .out_trap       (out_trap)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic load_vectors();
        int    fd;
        int    found;
        string line;
        fd = $fopen("verification/rv32_decode_input.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open the vector file");
        end
        while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 8 || line.getc(0) == "/") begin
                continue;  // Blank or comment line
            end
            found = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                vec_field[num_vectors][0], vec_field[num_vectors][1],
                vec_field[num_vectors][2], vec_field[num_vectors][3],
                vec_field[num_vectors][4], vec_field[num_vectors][5],
                vec_field[num_vectors][6], vec_field[num_vectors][7],
                vec_field[num_vectors][8], vec_field[num_vectors][9],
                vec_field[num_vectors][10], vec_field[num_vectors][11]);
            if (found != NUM_COLUMNS) begin
                report_failure("A line of the vector file has the wrong number of columns");
            end
            num_vectors++;
        end
        $fclose(fd);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            report_failure($sformatf("FAILED %s: got %h, expected %h (vector %0d, instr %h)",
                name, got, expected, out_count, vec_field[out_count][0]));
        end
    endtask

    task automatic check_outputs();
        check_field("out_opcode", 32'(out_opcode), vec_field[out_count][1]);
        check_field("out_type", 32'(out_type), vec_field[out_count][2]);
        check_field("out_alu_op", 32'(out_alu_op), vec_field[out_count][3]);
        check_field("out_imm", out_imm, vec_field[out_count][4]);
        check_field("out_rd", 32'(out_rd), vec_field[out_count][5]);
        check_field("out_rs1", 32'(out_rs1), vec_field[out_count][6]);
        check_field("out_rs2", 32'(out_rs2), vec_field[out_count][7]);
        check_field("out_fence_pred", 32'(out_fence_pred), vec_field[out_count][8]);
        check_field("out_fence_succ", 32'(out_fence_succ), vec_field[out_count][9]);
        check_field("out_zimm", 32'(out_zimm), vec_field[out_count][10]);
        check_field("out_trap", 32'(out_trap), vec_field[out_count][11]);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 10 * num_vectors + 100) begin
            report_failure($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                cycle_count, out_count, num_vectors));
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= ($urandom % 10) < 7;  // Low about 30% of cycles
        end
    end

    // Handshakes are sampled mid-cycle, transfers land on the next edge
    always @(negedge clk) begin
        if (!reset) begin
            assert (in_count - out_count <= QUEUE_DEPTH + 1) else begin
                report_failure("More items in flight than the stage can hold");
            end
            if (!in_ready) begin
                assert (in_count - out_count == QUEUE_DEPTH + 1) else begin
                    report_failure("in_ready went low while the stage was not full");
                end
            end
            if (in_valid && in_ready) begin
                in_count++;
            end
            if (out_valid && out_ready) begin
                assert (out_count < num_vectors) else begin
                    report_failure("An output appeared after all vectors were checked");
                end
                check_outputs();
                out_count++;
            end
        end
    end

    initial begin
        int gap;
        int i;
        void'($urandom(32'h03c6_54e1));
        reset    = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        out_ready = 1'b0;
        load_vectors();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!out_valid && in_ready) else begin
            report_failure("Stage is not empty and ready after reset");
        end
        @(posedge clk);
        for (i = 0; i < num_vectors; i++) begin
            gap = int'($urandom % 4);
            if (gap > 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            in_valid <= 1'b1;
            in_instr <= vec_field[i][0];
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            @(posedge clk);  // Transfer edge
        end
        in_valid <= 1'b0;
        while (out_count < num_vectors) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);  // Watch for stray outputs
        if (out_count == num_vectors && in_count == num_vectors) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_failure("Number of results does not match the number of vectors");
        end
    end

endmodule

//--- source/rv32_decode_top.sv
// ----------------------------------------------------------------------
// RV32I decode stage: instruction queue, decoder, output slice.
// Up to QUEUE_DEPTH + 1 instructions in flight.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rv32_decode_top #(
    parameter int QUEUE_DEPTH = rv32_pkg::RV32_QUEUE_DEPTH_DEFAULT
) (
    input  logic                        clk,
    input  logic                        reset,
    input  rv32_pkg::rv32_instr_t       in_instr,
    input  logic                        in_valid,
    output logic                        in_ready,
    output logic                        out_valid,
    input  logic                        out_ready,
    output rv32_pkg::rv32_opcode_enum_t out_opcode,
    output rv32_pkg::rv32_type_enum_t   out_type,
    output rv32_pkg::rv32_alu_op_t      out_alu_op,
    output rv32_pkg::rv32_register_t    out_rs1,
    output rv32_pkg::rv32_register_t    out_rs2,
    output rv32_pkg::rv32_register_t    out_rd,
    output rv32_pkg::rv32_imm_t         out_imm,
    output rv32_pkg::rv32_fence_t       out_fence_pred,
    output rv32_pkg::rv32_fence_t       out_fence_succ,
    output rv32_pkg::rv32_zimm_t        out_zimm,
    output logic                        out_trap
);

    import rv32_pkg::*;

    rv32_instr_t       q_instr;
    logic              q_valid;
    logic              q_ready;
    rv32_opcode_enum_t dec_opcode;
    rv32_type_enum_t   dec_type;
    rv32_alu_op_t      dec_alu_op;
    rv32_register_t    dec_rs1;
    rv32_register_t    dec_rs2;
    rv32_register_t    dec_rd;
    rv32_imm_t         dec_imm;
    rv32_fence_t       dec_fence_pred;
    rv32_fence_t       dec_fence_succ;
    rv32_zimm_t        dec_zimm;
    logic              dec_trap;

    rv32_instr_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) queue_inst (
        .clk      (clk),
        .reset    (reset),
        .in_instr (in_instr),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .q_instr  (q_instr),
        .q_valid  (q_valid),
        .q_ready  (q_ready)
    );

    rv32_decoder decoder_inst (
        .instr      (q_instr),
        .opcode     (dec_opcode),
        .inst_type  (dec_type),
        .alu_op     (dec_alu_op),
        .rs1        (dec_rs1),
        .rs2        (dec_rs2),
        .rd         (dec_rd),
        .imm        (dec_imm),
        .fence_pred (dec_fence_pred),
        .fence_succ (dec_fence_succ),
        .zimm       (dec_zimm),
        .trap       (dec_trap)
    );

    rv32_decode_reg decode_reg_inst (
        .clk            (clk),
        .reset          (reset),
        .q_valid        (q_valid),
        .q_ready        (q_ready),
        .opcode         (dec_opcode),
        .inst_type      (dec_type),
        .alu_op         (dec_alu_op),
        .rs1            (dec_rs1),
        .rs2            (dec_rs2),
        .rd             (dec_rd),
        .imm            (dec_imm),
        .fence_pred     (dec_fence_pred),
        .fence_succ     (dec_fence_succ),
        .zimm           (dec_zimm),
        .trap           (dec_trap),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_opcode     (out_opcode),
        .out_type       (out_type),
        .out_alu_op     (out_alu_op),
        .out_rs1        (out_rs1),
        .out_rs2        (out_rs2),
        .out_rd         (out_rd),
        .out_imm        (out_imm),
        .out_fence_pred (out_fence_pred),
        .out_fence_succ (out_fence_succ),
        .out_zimm       (out_zimm),
        .out_trap       (out_trap)
    );

endmodule

//--- source/rv32_decode_reg.sv
// ----------------------------------------------------------------------
// Output slice for decoded fields. Holds its contents while out_ready
// is low; q_ready depends combinationally on out_ready.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rv32_decode_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        q_valid,
    output logic                        q_ready,
    input  rv32_pkg::rv32_opcode_enum_t opcode,
    input  rv32_pkg::rv32_type_enum_t   inst_type,
    input  rv32_pkg::rv32_alu_op_t      alu_op,
    input  rv32_pkg::rv32_register_t    rs1,
    input  rv32_pkg::rv32_register_t    rs2,
    input  rv32_pkg::rv32_register_t    rd,
    input  rv32_pkg::rv32_imm_t         imm,
    input  rv32_pkg::rv32_fence_t       fence_pred,
    input  rv32_pkg::rv32_fence_t       fence_succ,
    input  rv32_pkg::rv32_zimm_t        zimm,
    input  logic                        trap,
    output logic                        out_valid,
    input  logic                        out_ready,
    output rv32_pkg::rv32_opcode_enum_t out_opcode,
    output rv32_pkg::rv32_type_enum_t   out_type,
    output rv32_pkg::rv32_alu_op_t      out_alu_op,
    output rv32_pkg::rv32_register_t    out_rs1,
    output rv32_pkg::rv32_register_t    out_rs2,
    output rv32_pkg::rv32_register_t    out_rd,
    output rv32_pkg::rv32_imm_t         out_imm,
    output rv32_pkg::rv32_fence_t       out_fence_pred,
    output rv32_pkg::rv32_fence_t       out_fence_succ,
    output rv32_pkg::rv32_zimm_t        out_zimm,
    output logic                        out_trap
);

    logic load;

    assign q_ready = !out_valid || out_ready;  // Empty or draining
    assign load    = q_valid && q_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (q_ready) begin
            out_valid <= q_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_opcode     <= opcode;
            out_type       <= inst_type;
            out_alu_op     <= alu_op;
            out_rs1        <= rs1;
            out_rs2        <= rs2;
            out_rd         <= rd;
            out_imm        <= imm;
            out_fence_pred <= fence_pred;
            out_fence_succ <= fence_succ;
            out_zimm       <= zimm;
            out_trap       <= trap;
        end
    end

endmodule

//--- source/rv32_instr_queue.sv
// ----------------------------------------------------------------------
// Instruction FIFO, DEPTH a power of two and at least 2. A push is
// accepted when full if the head leaves in the same cycle.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rv32_instr_queue #(
    parameter int DEPTH = rv32_pkg::RV32_QUEUE_DEPTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  reset,
    input  rv32_pkg::rv32_instr_t in_instr,
    input  logic                  in_valid,
    output logic                  in_ready,
    output rv32_pkg::rv32_instr_t q_instr,
    output logic                  q_valid,
    input  logic                  q_ready
);

    import rv32_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    rv32_instr_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign q_valid  = (count != '0);
    assign in_ready = (count != CNT_W'(DEPTH)) || q_ready;
    assign push     = in_valid && in_ready;
    assign pop      = q_valid && q_ready;
    assign q_instr  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

//--- source/rv32_decoder.sv
// ----------------------------------------------------------------------
// Combinational RV32I decoder. Shift amount and CSR address are read
// from the low bits of imm. Illegal encodings give UNKNOWN and trap.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rv32_decoder (
    input  rv32_pkg::rv32_instr_t       instr,
    output rv32_pkg::rv32_opcode_enum_t opcode,
    output rv32_pkg::rv32_type_enum_t   inst_type,
    output rv32_pkg::rv32_alu_op_t      alu_op,
    output rv32_pkg::rv32_register_t    rs1,
    output rv32_pkg::rv32_register_t    rs2,
    output rv32_pkg::rv32_register_t    rd,
    output rv32_pkg::rv32_imm_t         imm,
    output rv32_pkg::rv32_fence_t       fence_pred,
    output rv32_pkg::rv32_fence_t       fence_succ,
    output rv32_pkg::rv32_zimm_t        zimm,
    output logic                        trap
);

    import rv32_pkg::*;

    always_comb begin
        opcode    = RV32_UNKNOWN;
        inst_type = RV32_TYPE_UNKNOWN;
        case (instr[6:0])
            7'b0110111: inst_type = RV32_TYPE_U;   // LUI
            7'b0010111: inst_type = RV32_TYPE_U;   // AUIPC
            7'b1101111: inst_type = RV32_TYPE_J;   // JAL
            7'b1100011: inst_type = RV32_TYPE_B;
            7'b0100011: inst_type = RV32_TYPE_S;
            7'b0110011: inst_type = RV32_TYPE_R;
            7'b0010011: inst_type = (instr[31:7] == '0) ? RV32_TYPE_NOP : RV32_TYPE_I;
            7'b1100111, 7'b0000011, 7'b0001111, 7'b1110011: inst_type = RV32_TYPE_I;
            default: inst_type = RV32_TYPE_UNKNOWN;
        endcase

        case (instr[6:0])
            7'b0110111: opcode = RV32_LUI;
            7'b0010111: opcode = RV32_AUIPC;
            7'b1101111: opcode = RV32_JAL;
            7'b1100111: if (instr[14:12] == 3'b000) opcode = RV32_JALR;
            7'b1100011: begin
                case (instr[14:12])
                    3'b000: opcode = RV32_BEQ;
                    3'b001: opcode = RV32_BNE;
                    3'b100: opcode = RV32_BLT;
                    3'b101: opcode = RV32_BGE;
                    3'b110: opcode = RV32_BLTU;
                    3'b111: opcode = RV32_BGEU;
                    default: opcode = RV32_UNKNOWN;
                endcase
            end
            7'b0000011: begin
                case (instr[14:12])
                    3'b000: opcode = RV32_LB;
                    3'b001: opcode = RV32_LH;
                    3'b010: opcode = RV32_LW;
                    3'b100: opcode = RV32_LBU;
                    3'b101: opcode = RV32_LHU;
                    default: opcode = RV32_UNKNOWN;
                endcase
            end
            7'b0100011: begin
                case (instr[14:12])
                    3'b000: opcode = RV32_SB;
                    3'b001: opcode = RV32_SH;
                    3'b010: opcode = RV32_SW;
                    default: opcode = RV32_UNKNOWN;
                endcase
            end
            7'b0010011: begin
                case ({instr[31:7] == '0, instr[14:12]})
                    4'b1000: opcode = RV32_NOP;
                    4'b0000: opcode = RV32_ADDI;
                    4'b0010: opcode = RV32_SLTI;
                    4'b0011: opcode = RV32_SLTIU;
                    4'b0100: opcode = RV32_XORI;
                    4'b0110: opcode = RV32_ORI;
                    4'b0111: opcode = RV32_ANDI;
                    4'b0001: if (instr[31:25] == 7'b0000000) opcode = RV32_SLLI;
                    4'b0101: begin
                        if (instr[31:25] == 7'b0000000) opcode = RV32_SRLI;
                        if (instr[31:25] == 7'b0100000) opcode = RV32_SRAI;
                    end
                    default: opcode = RV32_UNKNOWN;
                endcase
            end
            7'b0110011: begin
                case ({instr[31:25], instr[14:12]})
                    {7'b0000000, 3'b000}: opcode = RV32_ADD;
                    {7'b0100000, 3'b000}: opcode = RV32_SUB;
                    {7'b0000000, 3'b001}: opcode = RV32_SLL;
                    {7'b0000000, 3'b010}: opcode = RV32_SLT;
                    {7'b0000000, 3'b011}: opcode = RV32_SLTU;
                    {7'b0000000, 3'b100}: opcode = RV32_XOR;
                    {7'b0000000, 3'b101}: opcode = RV32_SRL;
                    {7'b0100000, 3'b101}: opcode = RV32_SRA;
                    {7'b0000000, 3'b110}: opcode = RV32_OR;
                    {7'b0000000, 3'b111}: opcode = RV32_AND;
                    default: opcode = RV32_UNKNOWN;
                endcase
            end
            7'b0001111: begin
                // FENCE needs fm, rs1 and rd zero, FENCE.I everything but funct3
                if (instr[14:12] == 3'b000 && {instr[31:28], instr[19:15], instr[11:7]} == '0)
                    opcode = RV32_FENCE;
                if (instr[14:12] == 3'b001 && {instr[31:15], instr[11:7]} == '0)
                    opcode = RV32_FENCEI;
            end
            7'b1110011: begin
                case (instr[14:12])
                    3'b000: begin
                        if ({instr[31:15], instr[11:7]} == 22'h0) opcode = RV32_ECALL;
                        if ({instr[31:15], instr[11:7]} == 22'h400) opcode = RV32_EBREAK;
                    end
                    3'b001: opcode = RV32_CSRRW;
                    3'b010: opcode = RV32_CSRRS;
                    3'b011: opcode = RV32_CSRRC;
                    3'b101: opcode = RV32_CSRRWI;
                    3'b110: opcode = RV32_CSRRSI;
                    3'b111: opcode = RV32_CSRRCI;
                    default: opcode = RV32_UNKNOWN;
                endcase
            end
            default: opcode = RV32_UNKNOWN;
        endcase

        if (opcode == RV32_UNKNOWN) begin
            inst_type = RV32_TYPE_UNKNOWN;  // Also forces imm to zero
        end
    end

    always_comb begin
        case (opcode)
            RV32_LUI, RV32_AUIPC, RV32_JAL, RV32_JALR, RV32_LB, RV32_LH, RV32_LW,
            RV32_LBU, RV32_LHU, RV32_SB, RV32_SH, RV32_SW, RV32_ADDI,
            RV32_ADD:                          alu_op = RV32_ALU_ADD;
            RV32_SUB:                          alu_op = RV32_ALU_SUB;
            RV32_SLL, RV32_SLLI:               alu_op = RV32_ALU_SLL;
            RV32_SRL, RV32_SRLI:               alu_op = RV32_ALU_SRL;
            RV32_SRA, RV32_SRAI:               alu_op = RV32_ALU_SRA;
            RV32_SLT, RV32_SLTI, RV32_BLT:     alu_op = RV32_ALU_SLT;
            RV32_SLTU, RV32_SLTIU, RV32_BLTU:  alu_op = RV32_ALU_SLTU;
            RV32_XOR, RV32_XORI:               alu_op = RV32_ALU_XOR;
            RV32_OR, RV32_ORI:                 alu_op = RV32_ALU_OR;
            RV32_AND, RV32_ANDI:               alu_op = RV32_ALU_AND;
            RV32_BEQ:                          alu_op = RV32_ALU_EQ;
            RV32_BNE:                          alu_op = RV32_ALU_NEQ;
            RV32_BGE:                          alu_op = RV32_ALU_SGE;
            RV32_BGEU:                         alu_op = RV32_ALU_SGEU;
            default:                           alu_op = RV32_ALU_NOP;
        endcase
    end

    rv32_imm_gen imm_gen_inst (
        .instr    (instr),
        .imm_type (inst_type),
        .imm      (imm)
    );

    assign fence_pred = (opcode == RV32_FENCE) ? instr[27:24] : '0;
    assign fence_succ = (opcode == RV32_FENCE) ? instr[23:20] : '0;
    assign zimm = (opcode inside {RV32_CSRRWI, RV32_CSRRSI, RV32_CSRRCI}) ? instr[19:15] : '0;
    assign trap = (opcode == RV32_UNKNOWN);
    assign rs1  = instr[19:15];
    assign rs2  = instr[24:20];
    assign rd   = instr[11:7];

endmodule

//--- source/rv32_imm_gen.sv
// ----------------------------------------------------------------------
// Immediate assembly per format. R, NOP and UNKNOWN give zero.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rv32_imm_gen (
    input  rv32_pkg::rv32_instr_t     instr,
    input  rv32_pkg::rv32_type_enum_t imm_type,
    output rv32_pkg::rv32_imm_t       imm
);

    import rv32_pkg::*;

    always_comb begin
        case (imm_type)
            RV32_TYPE_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            RV32_TYPE_S: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            RV32_TYPE_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            RV32_TYPE_U: begin
                imm = {instr[31:12], 12'h000};  // Upper 20 bits, no extension
            end
            RV32_TYPE_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- source/rv32_pkg.sv
// ----------------------------------------------------------------------
// Shared types for the RV32I decode stage. Enum encodings are fixed
// because the testbench compares them as raw hex values.
// ----------------------------------------------------------------------
package rv32_pkg;

    typedef logic [31:0] rv32_instr_t;
    typedef logic [4:0]  rv32_register_t;
    typedef logic [31:0] rv32_imm_t;
    typedef logic [4:0]  rv32_zimm_t;
    typedef logic [3:0]  rv32_fence_t;

    // Decoded instruction, sequential from 0x00 up to CSRRCI at 0x2f
    typedef enum logic [5:0] {
        RV32_NOP     = 6'h00,
        RV32_LUI,                      // 0x01
        RV32_AUIPC,
        RV32_JAL,
        RV32_JALR,
        RV32_BEQ,                      // 0x05
        RV32_BNE,
        RV32_BLT,
        RV32_BGE,
        RV32_BLTU,
        RV32_BGEU,
        RV32_LB,                       // 0x0b
        RV32_LH,
        RV32_LW,
        RV32_LBU,
        RV32_LHU,
        RV32_SB,                       // 0x10
        RV32_SH,
        RV32_SW,
        RV32_ADDI,                     // 0x13
        RV32_SLTI,
        RV32_SLTIU,
        RV32_XORI,
        RV32_ORI,
        RV32_ANDI,
        RV32_SLLI,
        RV32_SRLI,
        RV32_SRAI,
        RV32_ADD,                      // 0x1c
        RV32_SUB,
        RV32_SLL,
        RV32_SLT,
        RV32_SLTU,
        RV32_XOR,
        RV32_SRL,
        RV32_SRA,
        RV32_OR,
        RV32_AND,
        RV32_FENCE,                    // 0x26
        RV32_FENCEI,
        RV32_ECALL,
        RV32_EBREAK,
        RV32_CSRRW,                    // 0x2a
        RV32_CSRRS,
        RV32_CSRRC,
        RV32_CSRRWI,
        RV32_CSRRSI,
        RV32_CSRRCI,
        RV32_UNKNOWN = 6'h3f
    } rv32_opcode_enum_t;

    typedef enum logic [2:0] {
        RV32_TYPE_R       = 3'd0,
        RV32_TYPE_I       = 3'd1,
        RV32_TYPE_S       = 3'd2,
        RV32_TYPE_B       = 3'd3,
        RV32_TYPE_U       = 3'd4,
        RV32_TYPE_J       = 3'd5,
        RV32_TYPE_NOP     = 3'd6,
        RV32_TYPE_UNKNOWN = 3'd7
    } rv32_type_enum_t;

    typedef enum logic [3:0] {
        RV32_ALU_NOP  = 4'd0,
        RV32_ALU_ADD  = 4'd1,
        RV32_ALU_SUB  = 4'd2,
        RV32_ALU_SLL  = 4'd3,
        RV32_ALU_SRL  = 4'd4,
        RV32_ALU_SRA  = 4'd5,
        RV32_ALU_SLT  = 4'd6,
        RV32_ALU_SLTU = 4'd7,
        RV32_ALU_XOR  = 4'd8,
        RV32_ALU_OR   = 4'd9,
        RV32_ALU_AND  = 4'd10,
        RV32_ALU_EQ   = 4'd11,
        RV32_ALU_NEQ  = 4'd12,
        RV32_ALU_SGE  = 4'd13,        // Signed greater or equal
        RV32_ALU_SGEU = 4'd14
    } rv32_alu_op_t;

    parameter int RV32_QUEUE_DEPTH_DEFAULT = 2;

endpackage
